// File: verilog/vdec_pkg.sv
package vdec_pkg;

    // Raw 32-bit instruction word
    typedef logic [31:0] instr_t;

    // Major opcodes in bits [6:0]
    typedef enum logic [6:0] {
        VMOC_LOAD    = 7'b0000111,
        VMOC_STORE   = 7'b0100111,
        VMOC_ALU_CFG = 7'b1010111,
        VMOC_INVALID = 7'b1111111
    } vmajor_t;

    // Arithmetic formats in funct3, OPCFG marks vset*
    typedef enum logic [2:0] {
        OPIVV = 3'b000,
        OPFVV = 3'b001,
        OPMVV = 3'b010,
        OPIVI = 3'b011,
        OPIVX = 3'b100,
        OPFVF = 3'b101,
        OPMVX = 3'b110,
        OPCFG = 3'b111
    } vfunct3_t;

    // Memory addressing mode in bits [27:26]
    typedef enum logic [1:0] {
        MOP_UNIT     = 2'b00,
        MOP_UINDEXED = 2'b01,
        MOP_STRIDED  = 2'b10,
        MOP_OINDEXED = 2'b11
    } mop_t;

    // Unit-stride sub-mode, shares the vs2 field
    typedef enum logic [4:0] {
        LUMOP_UNIT         = 5'b00000,
        LUMOP_UNIT_FULLREG = 5'b01000,
        LUMOP_UNIT_MASK    = 5'b01011
    } lumop_t;

    // Memory element width, shares the funct3 field
    typedef enum logic [2:0] {
        WIDTH8  = 3'b000,
        WIDTH16 = 3'b101,
        WIDTH32 = 3'b110
    } width_t;

    // Funct6 codes the decoder looks at
    localparam logic [5:0] FUNCT6_VWXUNARY0 = 6'b010000;
    localparam logic [5:0] FUNCT6_VNSRL     = 6'b101100;
    localparam logic [5:0] FUNCT6_VNSRA     = 6'b101101;
    localparam logic [5:0] FUNCT6_VNCLIPU   = 6'b101110;
    localparam logic [5:0] FUNCT6_VNCLIP    = 6'b101111;

    // Sliced fields plus classification flags
    typedef struct packed {
        logic [4:0] vd;
        logic [4:0] vs1;
        // Also lumop for unit-stride memory ops
        logic [4:0] vs2;
        vmajor_t    major;
        logic       vvalid;
        vfunct3_t   funct3;
        logic [5:0] funct6;
        mop_t       mop;
        width_t     mem_width;
        logic [2:0] nf_m1;
        logic       vm_bit;
        logic       is_cfg;
        logic       is_load;
        logic       is_store;
        logic       is_mem;
        logic       is_indexed;
        logic       is_opi;
    } vfields_t;

endpackage

// File: verilog/vctrl_pkg.sv
package vctrl_pkg;

    // Machine geometry
    localparam int NUM_LANES   = 4;
    localparam int LANE_SHIFT  = $clog2(NUM_LANES);
    localparam int VLENB       = 16;
    localparam int REG_IDX_W   = 5;
    localparam int WORD_W      = 32;
    localparam int UOP_NUM_W   = 8;
    localparam int REG_OFF_W   = 3;
    localparam int VTYPE_IMM_W = 11;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [REG_IDX_W-1:0] regsel_t;
    typedef logic [VTYPE_IMM_W-1:0] vtype_imm_t;

    // Element width, one step per doubling
    typedef enum logic [1:0] {
        SEW8  = 2'd0,
        SEW16 = 2'd1,
        SEW32 = 2'd2
    } vsew_t;

    // Which vset* flavour, if any
    typedef enum logic [1:0] {
        NOT_CFG  = 2'd0,
        VSETVLI  = 2'd1,
        VSETIVLI = 2'd2,
        VSETVL   = 2'd3
    } vsetvl_t;

    // Per-cycle micro-op info
    typedef struct packed {
        logic [UOP_NUM_W-1:0] uop_num;
        logic [REG_OFF_W-1:0] reg_offset;
        logic [NUM_LANES-1:0] lane_active;
    } vuop_t;

    // Full decoded control word
    typedef struct packed {
        vsetvl_t    vsetvl_type;
        vtype_imm_t vtype_imm;
        logic       vkeepvl;
        logic       vmask_en;
        logic       sregwen;
        logic       vregwen;
        logic       vxin1_use_imm;
        logic       vxin1_use_rs1;
        logic       vxin2_use_rs2;
        regsel_t    vd_sel;
        regsel_t    vs1_sel;
        regsel_t    vs2_sel;
        vsew_t      veew_src1;
        vsew_t      veew_src2;
        vsew_t      veew_dest;
        logic       vmemdren;
        logic       vmemdwen;
        logic       vunitstride;
        logic       vstrided;
        logic       vindexed;
        word_t      evl;
        vuop_t      uop;
    } vcontrol_t;

endpackage

// File: verilog/vinstr_fields.sv
`timescale 1ns/100ps

module vinstr_fields (
    input  vdec_pkg::instr_t   instr,
    output vdec_pkg::vfields_t fields
);

    import vdec_pkg::*;

    vmajor_t  major;
    vfunct3_t funct3;
    mop_t     mop;
    logic     is_alu;
    logic     is_mem;

    // Opcode lookup, anything else is not a vector op
    always_comb begin
        case (instr[6:0])
            VMOC_LOAD:    major = VMOC_LOAD;
            VMOC_STORE:   major = VMOC_STORE;
            VMOC_ALU_CFG: major = VMOC_ALU_CFG;
            default:      major = VMOC_INVALID;
        endcase
    end

    assign funct3 = vfunct3_t'(instr[14:12]);
    assign mop    = mop_t'(instr[27:26]);
    assign is_alu = (major == VMOC_ALU_CFG);
    assign is_mem = (major == VMOC_LOAD) || (major == VMOC_STORE);

    always_comb begin
        // Register fields, vd doubles as rd and vs3
        fields.vd  = instr[11:7];
        fields.vs1 = instr[19:15];
        fields.vs2 = instr[24:20];

        fields.major  = major;
        fields.vvalid = (major != VMOC_INVALID);
        fields.funct3 = funct3;
        fields.funct6 = instr[31:26];

        // Memory encoding overlaps funct3 and funct6
        fields.mop       = mop;
        fields.mem_width = width_t'(instr[14:12]);
        fields.nf_m1     = instr[31:29];
        fields.vm_bit    = instr[25];

        // vset* lives in the ALU opcode under OPCFG
        fields.is_cfg   = is_alu && (funct3 == OPCFG);
        fields.is_load  = (major == VMOC_LOAD);
        fields.is_store = (major == VMOC_STORE);
        fields.is_mem   = is_mem;

        // Both ordered and unordered indexed modes
        fields.is_indexed = is_mem && ((mop == MOP_UINDEXED) || (mop == MOP_OINDEXED));

        // Integer formats only
        fields.is_opi = is_alu &&
                        ((funct3 == OPIVV) || (funct3 == OPIVI) || (funct3 == OPIVX));
    end

endmodule

// File: verilog/vcfg_decode.sv
`timescale 1ns/100ps

module vcfg_decode (
    input  vdec_pkg::vfields_t    fields,
    output vctrl_pkg::vsetvl_t    cfg_type,
    output vctrl_pkg::vtype_imm_t vtype_imm,
    output logic                  vkeepvl,
    output logic                  sregwen
);

    import vdec_pkg::*;
    import vctrl_pkg::*;

    logic zero_regs;

    // rd and rs1 both x0 keeps the current vl
    assign zero_regs = (fields.vd == '0) && (fields.vs1 == '0);

    always_comb begin
        cfg_type  = NOT_CFG;
        vtype_imm = '0;
        vkeepvl   = 1'b0;

        if (fields.is_cfg) begin
            // funct6[5:4] are instruction bits 31..30
            if (!fields.funct6[5]) begin
                cfg_type  = VSETVLI;
                vtype_imm = {fields.funct6[4:0], fields.vm_bit, fields.vs2};
                vkeepvl   = zero_regs;
            end else if (fields.funct6[4]) begin
                // Only 10 immediate bits, rs1 slot holds the AVL
                cfg_type  = VSETIVLI;
                vtype_imm = {1'b0, fields.funct6[3:0], fields.vm_bit, fields.vs2};
            end else begin
                // vtype comes from rs2 at execute
                cfg_type = VSETVL;
                vkeepvl  = zero_regs;
            end
        end
    end

    // vset* writes vl to rd, VWXUNARY0 moves an element to a scalar
    assign sregwen = fields.is_cfg ||
                     ((fields.major == VMOC_ALU_CFG) && (fields.funct3 == OPMVV) &&
                      (fields.funct6 == FUNCT6_VWXUNARY0));

endmodule

// File: verilog/vwidth_evl.sv
`timescale 1ns/100ps

module vwidth_evl (
    input  vdec_pkg::vfields_t fields,
    input  vctrl_pkg::vsew_t   vsew,
    input  vctrl_pkg::word_t   vl,
    output vctrl_pkg::vsew_t   veew_src1,
    output vctrl_pkg::vsew_t   veew_src2,
    output vctrl_pkg::vsew_t   veew_dest,
    output vctrl_pkg::word_t   evl
);

    import vdec_pkg::*;
    import vctrl_pkg::*;

    vsew_t twice_vsew;
    vsew_t mem_eew;
    logic  narrowing;
    logic  widening;
    logic  unit_mem;
    logic  [3:0] nf;
    word_t mask_evl;
    word_t wholereg_evl;

    assign twice_vsew = vsew_t'(vsew + 2'd1);

    // Narrowing shifts and clips, integer formats only
    assign narrowing = fields.is_opi &&
                       ((fields.funct6 == FUNCT6_VNSRL)   || (fields.funct6 == FUNCT6_VNSRA) ||
                        (fields.funct6 == FUNCT6_VNCLIPU) || (fields.funct6 == FUNCT6_VNCLIP));

    // Widening ops sit in the 11xxxx funct6 block
    assign widening = (fields.major == VMOC_ALU_CFG) && (fields.funct6[5:4] == 2'b11);

    // Unlisted width codes fall back to 32 bit
    always_comb begin
        case (fields.mem_width)
            WIDTH8:  mem_eew = SEW8;
            WIDTH16: mem_eew = SEW16;
            default: mem_eew = SEW32;
        endcase
    end

    always_comb begin
        veew_src1 = vsew;
        veew_src2 = vsew;
        veew_dest = vsew;
        if (narrowing) begin
            veew_src2 = twice_vsew;
        end
        if (widening) begin
            veew_dest = twice_vsew;
        end
        // Data side takes the encoded width
        if (fields.is_mem && !fields.is_indexed) begin
            veew_src1 = mem_eew;
            veew_dest = mem_eew;
        end
        // Index vector takes the encoded width, data stays at vsew
        if (fields.is_indexed) begin
            veew_src2 = mem_eew;
        end
    end

    assign unit_mem = fields.is_mem && (fields.mop == MOP_UNIT);
    assign nf       = {1'b0, fields.nf_m1} + 4'd1;

    // One mask bit per element, rounded up to bytes
    assign mask_evl = (vl >> 3) + word_t'(|vl[2:0]);

    // Whole registers in elements of dest width
    assign wholereg_evl = (word_t'(nf) * word_t'(VLENB)) >> veew_dest;

    always_comb begin
        evl = vl;
        if (unit_mem && (lumop_t'(fields.vs2) == LUMOP_UNIT_MASK)) begin
            evl = mask_evl;
        end else if (unit_mem && (lumop_t'(fields.vs2) == LUMOP_UNIT_FULLREG)) begin
            evl = wholereg_evl;
        end
    end

endmodule

// File: verilog/vuop_gen.sv
`timescale 1ns/100ps

module vuop_gen (
    input  logic               CLK,
    input  logic               nRST,
    input  vdec_pkg::vfields_t fields,
    input  logic               stall,
    input  vctrl_pkg::vsew_t   veew_dest,
    input  vctrl_pkg::word_t   evl,
    output vctrl_pkg::vuop_t   uop,
    output logic               busy
);

    import vctrl_pkg::*;

    logic [UOP_NUM_W-1:0] uop_cnt;
    logic [UOP_NUM_W-1:0] uop_num;
    logic [UOP_NUM_W+1:0] scaled;
    logic                 gen;
    logic                 last_uop;
    word_t                total_uops;
    word_t                base_elem;

    // Vector ops only, vset* runs as a single step
    assign gen = fields.vvalid && !fields.is_cfg;

    // ceil(evl / lanes), never below one
    always_comb begin
        total_uops = (evl >> LANE_SHIFT) + word_t'(|evl[LANE_SHIFT-1:0]);
        if (total_uops == '0) begin
            total_uops = word_t'(1);
        end
    end

    assign last_uop = (word_t'(uop_cnt) + word_t'(1)) >= total_uops;
    assign busy     = gen && !last_uop;

    // Counter freezes while stalled, wraps after the last uop
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            uop_cnt <= '0;
        end else if (!stall) begin
            if (busy) begin
                uop_cnt <= uop_cnt + 1'b1;
            end else begin
                uop_cnt <= '0;
            end
        end
    end

    assign uop_num = gen ? uop_cnt : '0;

    // Bytes done so far over bytes per register
    assign scaled = {2'b00, uop_num} << veew_dest;

    // First element index covered by this uop
    assign base_elem = word_t'(uop_num) << LANE_SHIFT;

    always_comb begin
        uop.uop_num    = uop_num;
        uop.reg_offset = scaled[REG_OFF_W+1:2];
        // Tail lanes past evl stay off
        for (int i = 0; i < NUM_LANES; i++) begin
            uop.lane_active[i] = (base_elem + word_t'(i)) < evl;
        end
    end

endmodule

// File: verilog/vcontrol_unit.sv
`timescale 1ns/100ps

module vcontrol_unit (
    input  logic                  CLK,
    input  logic                  nRST,
    input  vdec_pkg::instr_t      instr,
    input  vctrl_pkg::vsew_t      vsew,
    input  vctrl_pkg::word_t      vl,
    input  logic                  stall,
    output vctrl_pkg::vcontrol_t  vcontrol,
    output logic                  vvalid,
    output logic                  vbusy
);

    import vdec_pkg::*;
    import vctrl_pkg::*;

    vfields_t   fields;
    vsetvl_t    cfg_type;
    vtype_imm_t vtype_imm;
    logic       vkeepvl;
    logic       sregwen;
    vsew_t      veew_src1;
    vsew_t      veew_src2;
    vsew_t      veew_dest;
    word_t      evl;
    vuop_t      uop;
    regsel_t    reg_off;
    logic       is_alu;

    vinstr_fields u_fields (
        .instr  (instr),
        .fields (fields)
    );

    vcfg_decode u_cfg (
        .fields    (fields),
        .cfg_type  (cfg_type),
        .vtype_imm (vtype_imm),
        .vkeepvl   (vkeepvl),
        .sregwen   (sregwen)
    );

    vwidth_evl u_width (
        .fields    (fields),
        .vsew      (vsew),
        .vl        (vl),
        .veew_src1 (veew_src1),
        .veew_src2 (veew_src2),
        .veew_dest (veew_dest),
        .evl       (evl)
    );

    vuop_gen u_uop (
        .CLK       (CLK),
        .nRST      (nRST),
        .fields    (fields),
        .stall     (stall),
        .veew_dest (veew_dest),
        .evl       (evl),
        .uop       (uop),
        .busy      (vbusy)
    );

    assign reg_off = regsel_t'(uop.reg_offset);
    assign is_alu  = (fields.major == VMOC_ALU_CFG);
    assign vvalid  = fields.vvalid;

    always_comb begin
        vcontrol.vsetvl_type = cfg_type;
        vcontrol.vtype_imm   = vtype_imm;
        vcontrol.vkeepvl     = vkeepvl;

        // vm=1 means unmasked
        vcontrol.vmask_en = ~fields.vm_bit;
        vcontrol.sregwen  = sregwen;
        vcontrol.vregwen  = fields.vvalid && !sregwen && !fields.is_store;

        // Scalar operand sources
        vcontrol.vxin1_use_imm = is_alu && (fields.funct3 == OPIVI);
        vcontrol.vxin1_use_rs1 = fields.is_mem ||
                                 (is_alu && ((fields.funct3 == OPIVX) ||
                                             (fields.funct3 == OPFVF) ||
                                             (fields.funct3 == OPMVX)));
        // rs2 is the stride, indexed ops read vs2 instead
        vcontrol.vxin2_use_rs2 = fields.is_mem && !fields.is_indexed;

        // Groups step through registers, index wraps at 32
        vcontrol.vd_sel  = fields.vd + reg_off;
        vcontrol.vs1_sel = (fields.is_store ? fields.vd : fields.vs1) + reg_off;
        vcontrol.vs2_sel = fields.vs2 + reg_off;

        vcontrol.veew_src1 = veew_src1;
        vcontrol.veew_src2 = veew_src2;
        vcontrol.veew_dest = veew_dest;

        vcontrol.vmemdren    = fields.is_load;
        vcontrol.vmemdwen    = fields.is_store;
        vcontrol.vunitstride = fields.is_mem && (fields.mop == MOP_UNIT);
        vcontrol.vstrided    = fields.is_mem && (fields.mop == MOP_STRIDED);
        vcontrol.vindexed    = fields.is_indexed;

        vcontrol.evl = evl;
        vcontrol.uop = uop;
    end

endmodule

// File: dv/tb_vcontrol_unit.sv
`timescale 1ns/100ps

module tb_vcontrol_unit;

    import vdec_pkg::*;
    import vctrl_pkg::*;

    localparam int CLK_PERIOD       = 20;
    localparam int RESET_CYCLES     = 5;
    localparam int MAX_INSTR_CYCLES = 200;
    // Cycle budgets per test, worst uop count plus slack
    localparam int RESET_BUDGET = 8 + 2;
    localparam int CFG_BUDGET   = 12 * 2;
    localparam int ALU_BUDGET   = 16 * 6;
    localparam int MEM_BUDGET   = 12 * 10;
    localparam int EVL_BUDGET   = 12 * 34;
    localparam int STALL_BUDGET = 4 * 60;
    localparam int MISC_BUDGET  = 8 * 2;
    localparam int WATCHDOG_CYCLES = 2 * (RESET_BUDGET + CFG_BUDGET + ALU_BUDGET + MEM_BUDGET +
                                          EVL_BUDGET + STALL_BUDGET + MISC_BUDGET) +
                                     RESET_CYCLES + 100;

    logic      CLK;
    logic      nRST;
    instr_t    instr;
    vsew_t     vsew;
    word_t     vl;
    logic      stall;
    vcontrol_t vcontrol;
    logic      vvalid;
    logic      vbusy;

    int check_cnt;
    int err_cnt;
    int tests_passed;
    int tests_failed;

    vcontrol_unit u_dut (
        .CLK      (CLK),
        .nRST     (nRST),
        .instr    (instr),
        .vsew     (vsew),
        .vl       (vl),
        .stall    (stall),
        .vcontrol (vcontrol),
        .vvalid   (vvalid),
        .vbusy    (vbusy)
    );

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    function automatic logic is_vector(input instr_t ins);
        return (ins[6:0] == 7'h07) || (ins[6:0] == 7'h27) || (ins[6:0] == 7'h57);
    endfunction

    // vset* words run as one step with no uop sequence
    function automatic logic makes_uops(input instr_t ins);
        return is_vector(ins) && !((ins[6:0] == 7'h57) && (ins[14:12] == 3'b111));
    endfunction

    // Config and non-vector words never hold the pipe
    idle_without_uops: assert property (@(posedge CLK) disable iff (!nRST)
        !makes_uops(instr) |-> !vbusy)
        else begin
            $display("ERROR %0t: vbusy high for a word that yields no uops", $time);
            err_cnt++;
        end

    function automatic int uop_count(input word_t evl);
        return (evl == 0) ? 1 : int'((evl + 3) / 4);
    endfunction

    // Expected control word for uop k of an instruction
    function automatic vcontrol_t expect_ctrl(input instr_t ins, input vsew_t sew,
                                              input word_t len, input int k);
        vcontrol_t  c;
        logic [2:0] f3;
        logic [5:0] f6;
        logic [1:0] mop;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [4:0] off5;
        logic       ld;
        logic       st;
        logic       alu;
        logic       mem;
        logic       cfg;
        logic       idx;
        logic       opi;
        logic       sreg;
        vsew_t      wide;
        vsew_t      mew;
        word_t      n;
        word_t      off;
        int         i;
        f3   = ins[14:12];
        f6   = ins[31:26];
        mop  = ins[27:26];
        rd   = ins[11:7];
        rs1  = ins[19:15];
        rs2  = ins[24:20];
        ld   = (ins[6:0] == 7'h07);
        st   = (ins[6:0] == 7'h27);
        alu  = (ins[6:0] == 7'h57);
        mem  = ld || st;
        cfg  = alu && (f3 == 3'b111);
        // Odd mop codes are the two indexed modes
        idx  = mem && mop[0];
        opi  = alu && ((f3 == 3'b000) || (f3 == 3'b011) || (f3 == 3'b100));
        sreg = cfg || (alu && (f3 == 3'b010) && (f6 == 6'b010000));
        wide = vsew_t'(sew + 2'd1);
        c = '0;
        if (cfg) begin
            if (!ins[31]) begin
                c.vsetvl_type = VSETVLI;
                c.vtype_imm   = ins[30:20];
                c.vkeepvl     = (rd == 5'd0) && (rs1 == 5'd0);
            end else if (ins[30]) begin
                c.vsetvl_type = VSETIVLI;
                c.vtype_imm   = {1'b0, ins[29:20]};
            end else begin
                c.vsetvl_type = VSETVL;
                c.vkeepvl     = (rd == 5'd0) && (rs1 == 5'd0);
            end
        end
        c.vmask_en      = !ins[25];
        c.sregwen       = sreg;
        c.vregwen       = (mem || alu) && !sreg && !st;
        c.vxin1_use_imm = alu && (f3 == 3'b011);
        c.vxin1_use_rs1 = mem || (alu && ((f3 == 3'b100) || (f3 == 3'b101) || (f3 == 3'b110)));
        c.vxin2_use_rs2 = mem && !idx;
        // Memory width code to element width
        case (f3)
            3'b000:  mew = SEW8;
            3'b101:  mew = SEW16;
            default: mew = SEW32;
        endcase
        c.veew_src1 = sew;
        c.veew_src2 = sew;
        c.veew_dest = sew;
        if (opi && (f6[5:2] == 4'b1011)) c.veew_src2 = wide;
        if (alu && (f6[5:4] == 2'b11)) c.veew_dest = wide;
        if (mem && !idx) begin
            c.veew_src1 = mew;
            c.veew_dest = mew;
        end
        if (idx) c.veew_src2 = mew;
        // Mask loads count bytes, whole-register loads count full registers
        c.evl = len;
        if (mem && (mop == 2'b00) && (rs2 == 5'b01011)) begin
            c.evl = (len + 7) / 8;
        end else if (mem && (mop == 2'b00) && (rs2 == 5'b01000)) begin
            c.evl = ((word_t'(ins[31:29]) + 1) * 16) >> c.veew_dest;
        end
        n    = makes_uops(ins) ? word_t'(k) : word_t'(0);
        off  = (n << c.veew_dest) >> 2;
        off5 = {2'b00, off[2:0]};
        c.uop.uop_num    = n[7:0];
        c.uop.reg_offset = off[2:0];
        for (i = 0; i < 4; i++) begin
            c.uop.lane_active[i] = (n * 4 + word_t'(i)) < c.evl;
        end
        // Store data comes from vs3 in the vd slot
        c.vd_sel      = rd + off5;
        c.vs1_sel     = (st ? rd : rs1) + off5;
        c.vs2_sel     = rs2 + off5;
        c.vmemdren    = ld;
        c.vmemdwen    = st;
        c.vunitstride = mem && (mop == 2'b00);
        c.vstrided    = mem && (mop == 2'b10);
        c.vindexed    = idx;
        return c;
    endfunction

    task automatic check_outputs(input vcontrol_t exp, input logic exp_valid,
                                 input logic exp_busy);
        vcontrol_t got_dec;
        vcontrol_t exp_dec;
        got_dec     = vcontrol;
        got_dec.uop = '0;
        exp_dec     = exp;
        exp_dec.uop = '0;
        check_cnt += 4;
        assert (got_dec === exp_dec) else begin
            $display("ERROR %0t: decode fields exp %h got %h", $time, exp_dec, got_dec);
            err_cnt++;
        end
        assert (vcontrol.uop === exp.uop) else begin
            $display("ERROR %0t: uop exp %h got %h", $time, exp.uop, vcontrol.uop);
            err_cnt++;
        end
        assert (vvalid === exp_valid) else begin
            $display("ERROR %0t: vvalid exp %b got %b", $time, exp_valid, vvalid);
            err_cnt++;
        end
        assert (vbusy === exp_busy) else begin
            $display("ERROR %0t: vbusy exp %b got %b", $time, exp_busy, vbusy);
            err_cnt++;
        end
    endtask

    // Present one instruction and follow it until its last uop leaves
    task automatic run_instr(input instr_t ins, input vsew_t sew, input word_t len,
                             input int stall_pct);
        vcontrol_t exp;
        vuop_t     prev_uop;
        logic      prev_busy;
        logic      prev_stall;
        logic      exp_busy;
        logic      done;
        int        k;
        int        issued;
        int        cycles;
        k          = 0;
        issued     = 0;
        cycles     = 0;
        done       = 1'b0;
        prev_uop   = '0;
        prev_busy  = 1'b0;
        prev_stall = 1'b0;
        @(negedge CLK);
        instr = ins;
        vsew  = sew;
        vl    = len;
        stall = ($urandom_range(99, 0) < stall_pct);
        while (!done) begin
            @(posedge CLK);
            exp      = expect_ctrl(ins, sew, len, k);
            exp_busy = makes_uops(ins) && ((k + 1) < uop_count(exp.evl));
            check_outputs(exp, is_vector(ins), exp_busy);
            if (prev_stall) begin
                check_cnt++;
                assert ((vcontrol.uop === prev_uop) && (vbusy === prev_busy)) else begin
                    $display("ERROR %0t: uop state moved during a stall", $time);
                    err_cnt++;
                end
            end
            prev_uop   = vcontrol.uop;
            prev_busy  = vbusy;
            prev_stall = stall;
            if (!stall) issued++;
            if (!stall && exp_busy) k++;
            done = !stall && !vbusy;
            cycles++;
            if (!done && (cycles >= MAX_INSTR_CYCLES)) begin
                $display("vbusy did not drop within %0d cycles for instruction %h",
                         MAX_INSTR_CYCLES, ins);
                err_cnt++;
                done = 1'b1;
            end
            if (!done) begin
                @(negedge CLK);
                stall = ($urandom_range(99, 0) < stall_pct);
            end
        end
        // Un-stalled cycles equal the uop count, one for vset* and non-vector words
        check_cnt++;
        assert (issued == (makes_uops(ins) ? uop_count(exp.evl) : 1)) else begin
            $display("ERROR %0t: %0d uops issued for %h", $time, issued, ins);
            err_cnt++;
        end
    endtask

    function automatic vsew_t random_sew();
        return vsew_t'($urandom_range(2, 0));
    endfunction

    function automatic logic [2:0] random_width();
        case ($urandom_range(3, 0))
            0:       return 3'b000;
            1:       return 3'b101;
            2:       return 3'b110;
            default: return 3'b111;
        endcase
    endfunction

    function automatic instr_t cfg_instr(input int kind);
        logic [4:0] rd;
        logic [4:0] rs1;
        logic       zero_regs;
        zero_regs = ($urandom_range(2, 0) == 0);
        rd        = zero_regs ? 5'd0 : 5'($urandom);
        rs1       = zero_regs ? 5'd0 : 5'($urandom);
        case (kind)
            0:       return {1'b0, 11'($urandom), rs1, 3'b111, rd, 7'h57};
            1:       return {2'b11, 10'($urandom), 5'($urandom), 3'b111, rd, 7'h57};
            default: return {7'b1000000, 5'($urandom), rs1, 3'b111, rd, 7'h57};
        endcase
    endfunction

    function automatic instr_t alu_instr(input logic [5:0] f6, input logic [2:0] f3);
        return {f6, 1'($urandom), 5'($urandom), 5'($urandom), f3, 5'($urandom), 7'h57};
    endfunction

    function automatic instr_t mem_instr(input logic store, input logic [1:0] mop,
                                         input logic [4:0] vs2, input logic [2:0] width,
                                         input logic [2:0] nf_m1);
        return {nf_m1, 1'b0, mop, 1'($urandom), vs2, 5'($urandom), width, 5'($urandom),
                store ? 7'h27 : 7'h07};
    endfunction

    task automatic finish_test(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            tests_passed++;
            $display("%-18s pass", name);
        end else begin
            tests_failed++;
            $display("%-18s fail, %0d errors", name, err_cnt - errs_before);
        end
    endtask

    // Hard stop if a sequence never completes
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        int         errs;
        int         i;
        logic [5:0] f6;
        logic [2:0] f3;
        logic [1:0] mop;
        logic [6:0] op;
        void'($urandom(43));
        CLK          = 1'b0;
        nRST         = 1'b0;
        instr        = '0;
        vsew         = SEW8;
        vl           = '0;
        // Stall stays high so the counter keeps its reset value
        stall        = 1'b1;
        check_cnt    = 0;
        err_cnt      = 0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (RESET_CYCLES) @(negedge CLK);
        nRST = 1'b1;

        // Idle after reset with an all-zero word
        errs = err_cnt;
        @(posedge CLK);
        check_cnt++;
        assert (!vbusy && (vcontrol.uop.uop_num == 8'd0)) else begin
            $display("ERROR %0t: not idle after reset", $time);
            err_cnt++;
        end
        // First long load starts its uops from the reset count
        run_instr(mem_instr(1'b0, 2'b00, 5'd0, 3'b000, 3'd0), SEW8, word_t'(32), 0);
        finish_test("reset idle", errs);

        errs = err_cnt;
        for (i = 0; i < 12; i++) begin
            run_instr(cfg_instr(i % 3), random_sew(), $urandom_range(32, 0), 0);
        end
        finish_test("config decode", errs);

        // Plain, narrowing, widening and VWXUNARY0 patterns in turn
        errs = err_cnt;
        for (i = 0; i < 16; i++) begin
            f3 = 3'($urandom_range(6, 0));
            case (i % 4)
                0: f6 = 6'($urandom);
                1: begin
                    f6 = {4'b1011, 2'($urandom)};
                    f3 = $urandom_range(1, 0) ? 3'b011 : 3'b000;
                end
                2: f6 = {2'b11, 4'($urandom)};
                default: begin
                    f6 = 6'b010000;
                    f3 = 3'b010;
                end
            endcase
            run_instr(alu_instr(f6, f3), random_sew(), $urandom_range(16, 1), 0);
        end
        finish_test("alu decode", errs);

        errs = err_cnt;
        for (i = 0; i < 12; i++) begin
            mop = 2'((i / 2) % 4);
            run_instr(mem_instr(1'(i % 2), mop, (mop == 2'b00) ? 5'd0 : 5'($urandom),
                                random_width(), 3'd0),
                      random_sew(), $urandom_range(32, 1), 0);
        end
        finish_test("memory uops", errs);

        // Mask loads then whole-register loads
        errs = err_cnt;
        for (i = 0; i < 12; i++) begin
            run_instr(mem_instr(1'b0, 2'b00, (i % 2 == 0) ? 5'b01011 : 5'b01000,
                                random_width(), 3'($urandom)),
                      random_sew(), $urandom_range(64, 1), 0);
        end
        finish_test("effective length", errs);

        errs = err_cnt;
        for (i = 0; i < 4; i++) begin
            run_instr(mem_instr(1'b0, 2'b00, 5'd0, random_width(), 3'd0),
                      random_sew(), $urandom_range(32, 20), 50);
        end
        finish_test("stall hold", errs);

        errs = err_cnt;
        for (i = 0; i < 6; i++) begin
            op = 7'($urandom);
            while (is_vector({25'd0, op})) op = 7'($urandom);
            run_instr({25'($urandom), op}, random_sew(), $urandom_range(32, 1), 0);
        end
        finish_test("non-vector", errs);

        $display("Tests passed %0d, failed %0d; checks %0d, errors %0d",
                 tests_passed, tests_failed, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: flist.f
verilog/vdec_pkg.sv
verilog/vctrl_pkg.sv
verilog/vinstr_fields.sv
verilog/vcfg_decode.sv
verilog/vwidth_evl.sv
verilog/vuop_gen.sv
verilog/vcontrol_unit.sv
dv/tb_vcontrol_unit.sv

// File: Makefile
TOP = tb_vcontrol_unit

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f flist.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir
